//--- sd_spi_controller.f
+incdir+include
verilog/sd_spi_pkg.sv
verilog/sd_spi_byte_engine.sv
verilog/sd_spi_sequencer.sv
verilog/sd_block_capture.sv
verilog/sd_spi_controller.sv
dv/sd_card_model.sv
dv/tb_sd_spi_controller.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_sd_spi_controller
FILELIST = sd_spi_controller.f
PASS_MSG = SIMULATION PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- dv/tb_sd_spi_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module tb_sd_spi_controller
    import sd_spi_pkg::*;
;

    localparam int CASES = 10;
    localparam int CASE_CYCLES = (6 + 256 + 256 + 512 + 2 + 5) * 16 * 4;
    localparam longint WATCHDOG_NS = longint'(CASES) * CASE_CYCLES * 100;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          clk_en = 1'b1;
    logic          start;
    sd_cmd_frame_t cmd_buffer_in;
    logic          spi_miso;
    sd_resp_t      cmd_buffer_out;
    logic          cmd_buffer_out_valid;
    sd_block_t     data_buffer_out;
    logic          data_buffer_out_valid;
    logic          busy;
    logic          interrupt;
    logic          spi_cs;
    logic          spi_clk;
    logic          spi_mosi;

    int            r1_delay = 0;
    sd_byte_t      r1_value = 8'h01;
    logic [31:0]   extra_bytes = '0;
    int            token_delay = -1;
    int            data_seed = 0;
    sd_cmd_frame_t seen_frame;
    logic          rand_en = 1'b0;
    logic          expecting = 1'b0;
    logic          exp_data = 1'b0;
    sd_resp_t      exp_resp = '0;

    sd_spi_controller sd_spi_controller_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .clk_en                (clk_en),
        .start                 (start),
        .cmd_buffer_in         (cmd_buffer_in),
        .spi_miso              (spi_miso),
        .cmd_buffer_out        (cmd_buffer_out),
        .cmd_buffer_out_valid  (cmd_buffer_out_valid),
        .data_buffer_out       (data_buffer_out),
        .data_buffer_out_valid (data_buffer_out_valid),
        .busy                  (busy),
        .interrupt             (interrupt),
        .spi_cs                (spi_cs),
        .spi_clk               (spi_clk),
        .spi_mosi              (spi_mosi)
    );

    sd_card_model card_i (
        .spi_cs      (spi_cs),
        .spi_clk     (spi_clk),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .r1_delay    (r1_delay),
        .r1_value    (r1_value),
        .extra_bytes (extra_bytes),
        .token_delay (token_delay),
        .data_seed   (data_seed),
        .seen_frame  (seen_frame)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        clk_en <= rand_en ? (($urandom % 3) != 0) : 1'b1;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input sd_byte_t got, input sd_byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run("byte compare failed");
        end
    endtask

    task automatic check_resp(input string name, input sd_resp_t got, input sd_resp_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run("response compare failed");
        end
    endtask

    task automatic check_block(input string name, input sd_block_t got, input sd_block_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run("data block compare failed");
        end
    endtask

    // a missing R1 or read token turns into a code in byte 0.
    function automatic sd_resp_t expected_resp(sd_opcode_e op, int r1_d, sd_byte_t r1,
                                               logic [31:0] extra, int tok_d);
        sd_resp_t r;
        r = '0;
        if (r1_d < 0) begin
            r[7:0] = `SD_IDLE_BYTE;
        end else begin
            r[7:0] = r1;
            if (op == CMD_SEND_IF_COND || op == CMD_READ_OCR) r[39:8] = extra;
            else if (op == CMD_READ_SINGLE && tok_d < 0) r[7:0] = `SD_TOKEN_TIMEOUT_CODE;
        end
        return r;
    endfunction

    function automatic sd_block_t expected_block(int seed);
        sd_block_t b;
        for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
            b[8*i +: 8] = 8'(seed + 7 * i);
        end
        return b;
    endfunction

    // checks every completion against the expected values set up for the case.
    always @(negedge clk) begin
        if (rst_n && interrupt) begin
            if (!expecting) abort_run("a second interrupt arrived with no transaction open");
            check_byte("cmd_buffer_out_valid", sd_byte_t'(cmd_buffer_out_valid), 8'h01);
            check_byte("busy", sd_byte_t'(busy), 8'h00);
            check_byte("spi_cs", sd_byte_t'(spi_cs), 8'h01);
            check_byte("spi_clk", sd_byte_t'(spi_clk), 8'h00);
            check_byte("data_buffer_out_valid", sd_byte_t'(data_buffer_out_valid),
                       sd_byte_t'(exp_data));
            check_resp("cmd_buffer_out", cmd_buffer_out, exp_resp);
            if (exp_data) check_block("data_buffer_out", data_buffer_out,
                                      expected_block(data_seed));
            expecting = 1'b0;
        end else if (rst_n && (cmd_buffer_out_valid || data_buffer_out_valid)) begin
            abort_run("a valid strobe arrived without an interrupt");
        end
    end

    task automatic run_case(input sd_opcode_e op, input int r1_d, input sd_byte_t r1,
                            input logic [31:0] extra, input int tok_d, input int seed);
        sd_cmd_frame_t frame;
        int            cycles;
        logic          done;
        frame = {8'h95, 32'($urandom), 2'b01, op};
        r1_delay = r1_d;
        r1_value = r1;
        extra_bytes = extra;
        token_delay = tok_d;
        data_seed = seed;
        exp_resp = expected_resp(op, r1_d, r1, extra, tok_d);
        exp_data = (op == CMD_READ_SINGLE) && (r1_d >= 0) && (tok_d >= 0);
        expecting = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        cmd_buffer_in <= frame;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) abort_run("start was never accepted");
        end while (!busy);
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (interrupt) begin
                done = 1'b1;
            end else begin
                check_byte("busy", sd_byte_t'(busy), 8'h01);
                check_byte("spi_cs", sd_byte_t'(spi_cs), 8'h00);
                if (cycles > CASE_CYCLES) abort_run("transaction never completed");
            end
            // a start while busy must not disturb the transaction.
            if (!done && cycles == 40) begin
                @(posedge clk);
                start <= 1'b1;
                cmd_buffer_in <= ~frame;
                @(posedge clk);
                start <= 1'b0;
                cmd_buffer_in <= frame;
            end
        end
        repeat (40) @(negedge clk);
        for (int i = 0; i < `SD_CMD_BYTES; i++) begin
            check_byte($sformatf("mosi byte %0d", i), seen_frame[8*i +: 8], frame[8*i +: 8]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all cases finished");
    end

    initial begin
        void'($urandom(32'h8d47_a14c));
        rst_n <= 1'b0;
        start <= 1'b0;
        cmd_buffer_in <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // outputs straight out of reset sit at their idle levels.
        @(negedge clk);
        check_byte("busy", sd_byte_t'(busy), 8'h00);
        check_byte("spi_cs", sd_byte_t'(spi_cs), 8'h01);
        check_byte("spi_clk", sd_byte_t'(spi_clk), 8'h00);
        check_byte("spi_mosi", sd_byte_t'(spi_mosi), 8'h01);
        check_resp("cmd_buffer_out", cmd_buffer_out, '0);
        check_block("data_buffer_out", data_buffer_out, '0);
        for (int pass = 0; pass < 2; pass++) begin
            run_case(CMD_GO_IDLE, 2, 8'h01, 32'h0, -1, 0);
            run_case(CMD_SEND_IF_COND, 1, 8'h01, $urandom, -1, 0);
            run_case(CMD_READ_OCR, 3, 8'h00, $urandom, -1, 0);
            run_case(CMD_READ_SINGLE, 0, 8'h00, 32'h0, int'($urandom % 200), int'($urandom));
            if (pass == 0) begin
                // no R1 at all, then a read whose token never comes.
                run_case(CMD_GO_IDLE, -1, 8'h01, 32'h0, -1, 0);
                run_case(CMD_READ_SINGLE, 1, 8'h00, 32'h0, -1, 0);
                rand_en = 1'b1;
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_card_model
    import sd_spi_pkg::*;
(
    input  logic          spi_cs,
    input  logic          spi_clk,
    input  logic          spi_mosi,
    output logic          spi_miso,
    input  int            r1_delay,
    input  sd_byte_t      r1_value,
    input  logic [31:0]   extra_bytes,
    input  int            token_delay,
    input  int            data_seed,
    output sd_cmd_frame_t seen_frame
);

    int       byte_cnt = 0;
    int       bit_cnt = 0;
    sd_byte_t rx_sr = 8'hFF;
    sd_byte_t tx_sr = 8'hFF;
    logic     miso_q = 1'b1;

    initial seen_frame = '0;

    assign spi_miso = miso_q;

    // a negative delay means the card never sends that byte.
    function automatic sd_byte_t reply_byte(int k);
        int   j;
        int   t;
        logic extra;
        logic read;
        j = k - `SD_CMD_BYTES;
        extra = (seen_frame[5:0] == 6'd8) || (seen_frame[5:0] == 6'd58);
        read = seen_frame[5:0] == 6'd17;
        if (j < 0 || r1_delay < 0 || j < r1_delay) return `SD_IDLE_BYTE;
        if (j == r1_delay) return r1_value;
        j = j - r1_delay - 1;
        if (extra) return (j < `SD_EXTRA_RESP_BYTES) ? extra_bytes[8*j +: 8] : `SD_IDLE_BYTE;
        if (!read || token_delay < 0 || j < token_delay) return `SD_IDLE_BYTE;
        if (j == token_delay) return `SD_DATA_TOKEN;
        t = j - token_delay - 1;
        // the CRC bytes after the block are sent as idle bytes.
        return (t < `SD_BLOCK_BYTES) ? 8'(data_seed + 7 * t) : `SD_IDLE_BYTE;
    endfunction

    // MISO moves right after each rise so it is settled for the next one.
    always @(posedge spi_clk or posedge spi_cs) begin
        if (spi_cs) begin
            byte_cnt = 0;
            bit_cnt = 0;
            tx_sr = `SD_IDLE_BYTE;
            miso_q = 1'b1;
        end else begin
            rx_sr = {rx_sr[6:0], spi_mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                if (byte_cnt < `SD_CMD_BYTES) seen_frame[8*byte_cnt +: 8] = rx_sr;
                byte_cnt = byte_cnt + 1;
                bit_cnt = 0;
                tx_sr = reply_byte(byte_cnt);
            end else begin
                tx_sr = {tx_sr[6:0], 1'b1};
            end
            miso_q = tx_sr[7];
        end
    end

endmodule

`default_nettype wire

//--- verilog/sd_spi_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sd_spi_controller
    import sd_spi_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clk_en,
    input  logic          start,
    input  sd_cmd_frame_t cmd_buffer_in,
    input  logic          spi_miso,
    output sd_resp_t      cmd_buffer_out,
    output logic          cmd_buffer_out_valid,
    output sd_block_t     data_buffer_out,
    output logic          data_buffer_out_valid,
    output logic          busy,
    output logic          interrupt,
    output logic          spi_cs,
    output logic          spi_clk,
    output logic          spi_mosi
);

    logic          run;
    logic          byte_done;
    sd_byte_t      tx_byte;
    sd_byte_t      rx_byte;
    logic          cap_clear;
    logic          data_we;
    logic          publish;
    sd_block_idx_t data_idx;

    sd_spi_byte_engine u_byte_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .run       (run),
        .spi_miso  (spi_miso),
        .tx_byte   (tx_byte),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi)
    );

    sd_spi_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .start     (start),
        .cmd_in    (cmd_buffer_in),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .run       (run),
        .spi_cs    (spi_cs),
        .tx_byte   (tx_byte),
        .cmd_out   (cmd_buffer_out),
        .cmd_valid (cmd_buffer_out_valid),
        .busy      (busy),
        .interrupt (interrupt),
        .cap_clear (cap_clear),
        .data_we   (data_we),
        .publish   (publish),
        .data_idx  (data_idx)
    );

    sd_block_capture u_block_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (cap_clear),
        .data_we    (data_we),
        .data_idx   (data_idx),
        .rx_byte    (rx_byte),
        .publish    (publish),
        .data_out   (data_buffer_out),
        .data_valid (data_buffer_out_valid)
    );

endmodule

`default_nettype wire

//--- verilog/sd_block_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sd_block_capture
    import sd_spi_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear,
    input  logic          data_we,
    input  sd_block_idx_t data_idx,
    input  sd_byte_t      rx_byte,
    input  logic          publish,
    output sd_block_t     data_out,
    output logic          data_valid
);

    sd_block_t capture;

    // bytes land little-endian by index as they arrive.
    always_ff @(posedge clk) begin
        if (clear) begin
            capture <= '0;
        end else if (data_we) begin
            capture[{data_idx, 3'b000} +: 8] <= rx_byte;
        end
    end

    // the published copy holds still while the next read fills capture.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out   <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= publish;
            if (publish) begin
                data_out <= capture;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sd_spi_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_spi_sequencer
    import sd_spi_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clk_en,
    input  logic          start,
    input  sd_cmd_frame_t cmd_in,
    input  sd_byte_t      rx_byte,
    input  logic          byte_done,
    output logic          run,
    output logic          spi_cs,
    output sd_byte_t      tx_byte,
    output sd_resp_t      cmd_out,
    output logic          cmd_valid,
    output logic          busy,
    output logic          interrupt,
    output logic          cap_clear,
    output logic          data_we,
    output logic          publish,
    output sd_block_idx_t data_idx
);

    sd_seq_state_e state;
    sd_cmd_frame_t cmd_frame;
    sd_resp_t      resp_q;
    sd_resp_t      resp_final;
    sd_opcode_e    opcode_in;
    logic          is_read;
    logic          has_extra;
    logic [2:0]    cmd_cnt;
    logic [2:0]    resp_cnt;
    logic [2:0]    resp_slot;
    sd_block_idx_t data_cnt;
    logic          crc_cnt;
    logic [7:0]    poll_cnt;
    logic          launch;
    logic          finish;
    logic          got_r1;
    logic          poll_expired;
    logic          last_extra;

    assign opcode_in    = sd_opcode_e'(cmd_in[5:0]);
    assign launch       = clk_en && start && (state == SEQ_IDLE);
    assign got_r1       = rx_byte != `SD_IDLE_BYTE;
    assign poll_expired = poll_cnt == 8'(`SD_WAIT_LIMIT - 1);
    assign resp_slot    = resp_cnt + 3'd1;
    assign last_extra   = resp_cnt == 3'(`SD_EXTRA_RESP_BYTES - 1);

    assign cap_clear = launch;
    assign data_we   = byte_done && (state == SEQ_READ_DATA);
    assign data_idx  = data_cnt;
    assign publish   = finish && (state == SEQ_READ_CRC);

    // decides whether this byte ends the transaction and what gets reported.
    always_comb begin
        finish     = 1'b0;
        resp_final = resp_q;
        if (byte_done) begin
            case (state)
                SEQ_WAIT_R1: begin
                    if (got_r1 && !has_extra && !is_read) begin
                        finish          = 1'b1;
                        resp_final[7:0] = rx_byte;
                    end else if (!got_r1 && poll_expired) begin
                        finish          = 1'b1;
                        resp_final[7:0] = `SD_IDLE_BYTE;
                    end
                end
                SEQ_READ_RESP: begin
                    if (last_extra) begin
                        finish = 1'b1;
                        resp_final[{resp_slot, 3'b000} +: 8] = rx_byte;
                    end
                end
                SEQ_WAIT_TOKEN: begin
                    if (rx_byte != `SD_DATA_TOKEN && poll_expired) begin
                        finish          = 1'b1;
                        resp_final[7:0] = `SD_TOKEN_TIMEOUT_CODE;
                    end
                end
                SEQ_READ_CRC: begin
                    finish = crc_cnt == 1'(`SD_CRC_BYTES - 1);
                end
                default: begin
                    finish = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_frame <= cmd_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            busy      <= 1'b0;
            run       <= 1'b0;
            spi_cs    <= 1'b1;
            tx_byte   <= `SD_IDLE_BYTE;
            cmd_out   <= '0;
            cmd_valid <= 1'b0;
            interrupt <= 1'b0;
            resp_q    <= '0;
            is_read   <= 1'b0;
            has_extra <= 1'b0;
            cmd_cnt   <= 3'd0;
            resp_cnt  <= 3'd0;
            data_cnt  <= '0;
            crc_cnt   <= 1'b0;
            poll_cnt  <= 8'd0;
        end else begin
            interrupt <= 1'b0;
            cmd_valid <= 1'b0;
            if (clk_en) begin
                case (state)
                    SEQ_IDLE: begin
                        if (start) begin
                            state     <= SEQ_SEND_CMD;
                            busy      <= 1'b1;
                            run       <= 1'b1;
                            spi_cs    <= 1'b0;
                            tx_byte   <= cmd_in[7:0];
                            resp_q    <= '0;
                            is_read   <= opcode_in == CMD_READ_SINGLE;
                            has_extra <= (opcode_in == CMD_SEND_IF_COND) ||
                                         (opcode_in == CMD_READ_OCR);
                            cmd_cnt   <= 3'd0;
                        end
                    end
                    SEQ_SEND_CMD: begin
                        if (byte_done) begin
                            if (cmd_cnt == 3'(`SD_CMD_BYTES - 1)) begin
                                state    <= SEQ_WAIT_R1;
                                tx_byte  <= `SD_IDLE_BYTE;
                                poll_cnt <= 8'd0;
                            end else begin
                                cmd_cnt <= cmd_cnt + 3'd1;
                                tx_byte <= cmd_frame[{cmd_cnt + 3'd1, 3'b000} +: 8];
                            end
                        end
                    end
                    SEQ_WAIT_R1: begin
                        if (byte_done) begin
                            poll_cnt <= poll_cnt + 8'd1;
                            if (got_r1) begin
                                resp_q[7:0] <= rx_byte;
                                if (has_extra) begin
                                    state    <= SEQ_READ_RESP;
                                    resp_cnt <= 3'd0;
                                end else if (is_read) begin
                                    state    <= SEQ_WAIT_TOKEN;
                                    poll_cnt <= 8'd0;
                                end
                            end
                        end
                    end
                    SEQ_READ_RESP: begin
                        if (byte_done) begin
                            resp_q[{resp_slot, 3'b000} +: 8] <= rx_byte;
                            resp_cnt <= resp_slot;
                        end
                    end
                    SEQ_WAIT_TOKEN: begin
                        if (byte_done) begin
                            poll_cnt <= poll_cnt + 8'd1;
                            if (rx_byte == `SD_DATA_TOKEN) begin
                                state    <= SEQ_READ_DATA;
                                data_cnt <= '0;
                            end
                        end
                    end
                    SEQ_READ_DATA: begin
                        if (byte_done) begin
                            data_cnt <= data_cnt + 1'b1;
                            if (data_cnt == sd_block_idx_t'(`SD_BLOCK_BYTES - 1)) begin
                                state   <= SEQ_READ_CRC;
                                crc_cnt <= 1'b0;
                            end
                        end
                    end
                    SEQ_READ_CRC: begin
                        // the CRC is clocked through and dropped.
                        if (byte_done) begin
                            crc_cnt <= crc_cnt + 1'b1;
                        end
                    end
                    SEQ_DONE: begin
                        state <= SEQ_IDLE;
                    end
                    default: begin
                        state <= SEQ_IDLE;
                    end
                endcase

                if (finish) begin
                    state     <= SEQ_DONE;
                    cmd_out   <= resp_final;
                    cmd_valid <= 1'b1;
                    interrupt <= 1'b1;
                    busy      <= 1'b0;
                    run       <= 1'b0;
                    spi_cs    <= 1'b1;
                end
            end
        end
    end

    ap_irq_with_resp: assert property (@(posedge clk) disable iff (!rst_n)
        interrupt |-> cmd_valid);

    ap_idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SEQ_IDLE) && $past((state == SEQ_IDLE) && clk_en) |-> !busy);

endmodule

`default_nettype wire

//--- verilog/sd_spi_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sd_spi_byte_engine
    import sd_spi_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clk_en,
    input  logic     run,
    input  logic     spi_miso,
    input  sd_byte_t tx_byte,
    output sd_byte_t rx_byte,
    output logic     byte_done,
    output logic     spi_clk,
    output logic     spi_mosi
);

    logic       phase;
    logic [2:0] bit_cnt;
    sd_byte_t   tx_shift;
    sd_byte_t   rx_shift;
    sd_byte_t   tx_src;
    logic       clk_q;
    logic       mosi_q;

    // a new byte is taken from the sequencer at the first low phase.
    assign tx_src = (bit_cnt == 3'd0) ? tx_byte : tx_shift;

    assign rx_byte   = {rx_shift[6:0], spi_miso};
    assign byte_done = run && clk_en && phase && (bit_cnt == 3'd7);

    // the pins drop to idle in the same cycle that run falls.
    assign spi_clk  = run && clk_q;
    assign spi_mosi = !run || mosi_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase   <= 1'b0;
            bit_cnt <= 3'd0;
            clk_q   <= 1'b0;
            mosi_q  <= 1'b1;
        end else if (!run) begin
            phase   <= 1'b0;
            bit_cnt <= 3'd0;
            clk_q   <= 1'b0;
            mosi_q  <= 1'b1;
        end else if (clk_en) begin
            if (!phase) begin
                clk_q  <= 1'b0;
                mosi_q <= tx_src[7];
                phase  <= 1'b1;
            end else begin
                clk_q   <= 1'b1;
                phase   <= 1'b0;
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // MISO is sampled on the rising half, MSB first.
    always_ff @(posedge clk) begin
        if (run && clk_en) begin
            if (!phase) begin
                tx_shift <= {tx_src[6:0], 1'b0};
            end else begin
                rx_shift <= rx_byte;
            end
        end
    end

    ap_done_gated: assert property (@(posedge clk) disable iff (!rst_n)
        byte_done |-> run && clk_en);

endmodule

`default_nettype wire

//--- verilog/sd_spi_pkg.sv
`default_nettype none

`include "sd_spi_defs.svh"

package sd_spi_pkg;

    typedef logic [7:0] sd_byte_t;
    typedef logic [8*`SD_CMD_BYTES-1:0] sd_cmd_frame_t;
    typedef logic [8*`SD_RESP_BYTES-1:0] sd_resp_t;
    typedef logic [8*`SD_BLOCK_BYTES-1:0] sd_block_t;
    typedef logic [$clog2(`SD_BLOCK_BYTES)-1:0] sd_block_idx_t;

    // command indices that change the shape of the transaction.
    typedef enum logic [5:0] {
        CMD_GO_IDLE      = 6'd0,
        CMD_SEND_IF_COND = 6'd8,
        CMD_READ_SINGLE  = 6'd17,
        CMD_READ_OCR     = 6'd58
    } sd_opcode_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SEND_CMD,
        SEQ_WAIT_R1,
        SEQ_READ_RESP,
        SEQ_WAIT_TOKEN,
        SEQ_READ_DATA,
        SEQ_READ_CRC,
        SEQ_DONE
    } sd_seq_state_e;

endpackage

`default_nettype wire

//--- include/sd_spi_defs.svh
`ifndef SD_SPI_DEFS_SVH
`define SD_SPI_DEFS_SVH

// frame and block sizes, in bytes.
`define SD_BLOCK_BYTES 512
`define SD_CMD_BYTES 6
`define SD_RESP_BYTES 6

// R3 and R7 carry four bytes after R1.
`define SD_EXTRA_RESP_BYTES 4
`define SD_CRC_BYTES 2

// tokens seen on the line.
`define SD_DATA_TOKEN 8'hFE
`define SD_IDLE_BYTE 8'hFF

// reported in response byte 0 when a read never sees its start token.
`define SD_TOKEN_TIMEOUT_CODE 8'h05

// poll limit for R1 and for the read token, in byte times.
`define SD_WAIT_LIMIT 256

`endif
